/* source/mul_pkg.sv */
package mul_pkg;

    //////////////////////////////////////////////////
    // operand and product widths
    //////////////////////////////////////////////////

    // width of one unsigned multiplier input
    localparam int OPERAND_WIDTH = 16;

    // full product needs twice the operand width
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // default multiplier depth, also the shell default
    localparam int MUL_DELAY = 3;

    //////////////////////////////////////////////////
    // payload types
    //////////////////////////////////////////////////

    // one unsigned operand
    typedef logic [OPERAND_WIDTH-1:0] operand_t;

    // both operands of one beat, a in the upper half
    typedef struct packed {
        operand_t a;
        operand_t b;
    } operand_pair_t;

    // unsigned product, never truncated
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

endpackage

/* source/axis_pkg.sv */
package axis_pkg;

    // product type for the output beat
    import mul_pkg::*;

    //////////////////////////////////////////////////
    // stream side band
    //////////////////////////////////////////////////

    // valid and last of one beat, delayed next to the data
    // zero means a bubble, which is also the reset value
    typedef struct packed {
        logic valid;
        logic last;
    } side_t;

    //////////////////////////////////////////////////
    // output beat
    //////////////////////////////////////////////////

    // what the skid buffer holds per entry
    // last rides with the data so both stay in step
    typedef struct packed {
        logic     last;
        product_t data;
    } out_beat_t;

endpackage

/* source/axis_if.sv */
`timescale 1ns/1ps

interface axis_if
    import mul_pkg::*;
#(
    // data carried on tdata
    parameter type data_t = product_t
);

    // handshake
    logic  tvalid;
    logic  tready;

    // payload
    logic  tlast;
    data_t tdata;

    // upstream side, drives the beat
    modport master (
        output tvalid,
        output tlast,
        output tdata,
        input  tready
    );

    // downstream side, answers with ready
    modport slave (
        input  tvalid,
        input  tlast,
        input  tdata,
        output tready
    );

endinterface

/* source/n_delay.sv */
`timescale 1ns/1ps

module n_delay #(
    // number of register stages, at least one
    parameter int  N = 3,
    // payload carried through the stages
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     arst_n,
    input  logic     clken,
    input  payload_t data_in,
    output payload_t data_out
);

    // one entry per stage, index 0 nearest the input
    payload_t pipe_q [N];

    //////////////////////////////////////////////////
    // shift register
    //////////////////////////////////////////////////

    // clears to zero so a flushed pipe holds only bubbles
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N; i++) begin
                pipe_q[i] <= '0;
            end
        end else if (clken) begin
            // shift by one only when pulled
            pipe_q[0] <= data_in;
            for (int i = 1; i < N; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    // oldest entry leaves
    assign data_out = pipe_q[N-1];

endmodule

/* source/pipe_multiplier.sv */
`timescale 1ns/1ps

module pipe_multiplier
    import mul_pkg::*;
#(
    // number of register stages, one partial product each
    parameter int DELAY = MUL_DELAY
) (
    input  logic          aclk,
    input  logic          arst_n,
    input  logic          clken,
    input  operand_pair_t operands,
    output product_t      product
);

    // b is cut into DELAY slices of this width
    localparam int SLICE_W = (OPERAND_WIDTH + DELAY - 1) / DELAY;
    // b zero padded to a whole number of slices
    localparam int PAD_W   = SLICE_W * DELAY;
    // width of a times one slice
    localparam int PP_W    = OPERAND_WIDTH + SLICE_W;

    typedef logic [PAD_W-1:0] b_pad_t;

    //////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////

    for (genvar i = 0; i < DELAY; i++) begin : g_stage
        // stage inputs, from the port or the previous stage
        operand_t           a_in;
        b_pad_t             b_in;
        product_t           acc_in;
        // this stage's slice of b and its partial product
        logic [SLICE_W-1:0] slice;
        logic [PP_W-1:0]    pp;
        // stage registers
        operand_t           a_q;
        b_pad_t             b_q;
        product_t           acc_q;

        if (i == 0) begin : g_first
            assign a_in   = operands.a;
            assign b_in   = b_pad_t'(operands.b);
            assign acc_in = '0;
        end else begin : g_next
            assign a_in   = g_stage[i-1].a_q;
            assign b_in   = g_stage[i-1].b_q;
            assign acc_in = g_stage[i-1].acc_q;
        end

        // slice i weighs 2^(i*SLICE_W)
        assign slice = b_in[i*SLICE_W +: SLICE_W];
        assign pp    = PP_W'(a_in) * PP_W'(slice);

        // operands travel with their running sum
        // so DELAY beats can be in flight
        always_ff @(posedge aclk or negedge arst_n) begin
            if (!arst_n) begin
                a_q   <= '0;
                b_q   <= '0;
                acc_q <= '0;
            end else if (clken) begin
                a_q   <= a_in;
                b_q   <= b_in;
                acc_q <= acc_in + (product_t'(pp) << (i * SLICE_W));
            end
        end
    end

    // sum of all slices, exact since padding bits are zero
    assign product = g_stage[DELAY-1].acc_q;

endmodule

/* source/skid_buffer.sv */
`timescale 1ns/1ps

module skid_buffer
    import mul_pkg::*, axis_pkg::*;
#(
    // entry type, needs last and data fields
    parameter type payload_t = out_beat_t
) (
    input  logic     aclk,
    input  logic     arst_n,
    // incoming stream from the pipe
    axis_if.slave    up,
    // outgoing stream
    output logic     m_tvalid,
    input  logic     m_tready,
    output product_t m_tdata,
    output logic     m_tlast
);

    // empty   nothing held
    // busy    output register holds a beat
    // full    output and spare both hold a beat
    typedef enum logic [1:0] {
        ST_EMPTY,
        ST_BUSY,
        ST_FULL
    } state_t;

    state_t   state_q;
    state_t   state_d;
    logic     ready_q;

    // beat offered by the pipe, output register and spare register
    payload_t in_beat;
    payload_t out_q;
    payload_t spare_q;

    // handshakes on both sides
    logic     insert;
    logic     remove;

    // datapath controls from the FSM
    logic     load_out;
    logic     load_spare;
    logic     from_spare;

    assign in_beat = payload_t'{last: up.tlast, data: up.tdata};
    assign insert  = up.tvalid && ready_q;
    assign remove  = m_tvalid && m_tready;

    //////////////////////////////////////////////////
    // occupancy FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_d    = state_q;
        load_out   = 1'b0;
        load_spare = 1'b0;
        from_spare = 1'b0;
        unique case (state_q)
            ST_EMPTY: begin
                // first beat goes straight to the output
                if (insert) begin
                    state_d  = ST_BUSY;
                    load_out = 1'b1;
                end
            end
            ST_BUSY: begin
                if (insert && !remove) begin
                    // stall caught one beat late, park it
                    state_d    = ST_FULL;
                    load_spare = 1'b1;
                end else if (insert && remove) begin
                    // flowing, replace the output
                    load_out = 1'b1;
                end else if (remove) begin
                    state_d = ST_EMPTY;
                end
            end
            ST_FULL: begin
                // refill from spare, upstream is held off
                if (remove) begin
                    state_d    = ST_BUSY;
                    load_out   = 1'b1;
                    from_spare = 1'b1;
                end
            end
            default: begin
                state_d = ST_EMPTY;
            end
        endcase
    end

    // ready registered from next state, low only when full
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_EMPTY;
            ready_q <= 1'b1;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d != ST_FULL);
        end
    end

    // output only reloads when empty or on a handshake
    always_ff @(posedge aclk) begin
        if (load_out) begin
            out_q <= from_spare ? spare_q : in_beat;
        end
        if (load_spare) begin
            spare_q <= in_beat;
        end
    end

    assign up.tready = ready_q;
    assign m_tvalid  = (state_q != ST_EMPTY);
    assign m_tdata   = out_q.data;
    assign m_tlast   = out_q.last;

endmodule

/* source/axis_mul_shell.sv */
`timescale 1ns/1ps

module axis_mul_shell
    import mul_pkg::*, axis_pkg::*;
#(
    // operand width used by the guard mask
    parameter int OPERAND_WIDTH = mul_pkg::OPERAND_WIDTH,
    // multiplier depth, shared with the side band delay
    parameter int DELAY         = MUL_DELAY
) (
    input  logic          aclk,
    input  logic          arst_n,
    // slave stream, operand pairs in
    input  operand_pair_t s_tdata,
    input  logic          s_tvalid,
    output logic          s_tready,
    input  logic          s_tlast,
    // master stream, products out
    output product_t      m_tdata,
    output logic          m_tvalid,
    input  logic          m_tready,
    output logic          m_tlast
);

    // clock enable of the whole pipe
    logic          pull;

    // guard stage
    operand_pair_t guard_in;
    operand_pair_t guard_ops;
    side_t         guard_side;

    // pipe outputs
    product_t      product;
    side_t         side_dly;

    // stream from the pipe into the skid buffer
    axis_if #(.data_t(product_t)) beat_if ();

    //////////////////////////////////////////////////
    // pull
    //////////////////////////////////////////////////

    // pipe moves only when the skid buffer can take a beat
    // no push, so bubbles flush through instead of being dropped
    assign pull     = beat_if.tready;
    // a slave beat is taken on the same enable
    assign s_tready = pull;

    //////////////////////////////////////////////////
    // guard stage
    //////////////////////////////////////////////////

    // invalid beats enter as zero operands
    assign guard_in = operand_pair_t'{
        a: s_tdata.a & {OPERAND_WIDTH{s_tvalid}},
        b: s_tdata.b & {OPERAND_WIDTH{s_tvalid}}
    };

    // valid and last registered with the data to stay tied to it
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            guard_ops  <= '0;
            guard_side <= '0;
        end else if (pull) begin
            guard_ops  <= guard_in;
            guard_side <= side_t'{valid: s_tvalid, last: s_tlast};
        end
    end

    //////////////////////////////////////////////////
    // multiplier and side band
    //////////////////////////////////////////////////

    pipe_multiplier #(
        .DELAY    (DELAY)
    ) u_mul (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .clken    (pull),
        .operands (guard_ops),
        .product  (product)
    );

    // same depth and enable keeps the flags aligned with the product
    n_delay #(
        .N         (DELAY),
        .payload_t (side_t)
    ) u_side_delay (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .clken     (pull),
        .data_in   (guard_side),
        .data_out  (side_dly)
    );

    //////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////

    // shell is the master of the internal stream
    assign beat_if.tvalid = side_dly.valid;
    assign beat_if.tlast  = side_dly.last;
    assign beat_if.tdata  = product;

    // turns m_tready back-pressure into pull
    skid_buffer #(
        .payload_t (out_beat_t)
    ) u_skid (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .up        (beat_if),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready),
        .m_tdata   (m_tdata),
        .m_tlast   (m_tlast)
    );

endmodule

/* test/axis_mul_assert.sv */
`timescale 1ns/1ps

module axis_mul_assert
    import mul_pkg::*;
(
    input logic     aclk,
    input logic     arst_n,
    input logic     m_tvalid,
    input logic     m_tready,
    input product_t m_tdata,
    input logic     m_tlast
);

    // failed assertions so far, read by the testbench
    int fail_count = 0;

    //////////////////////////////////////////////////
    // master stream protocol
    //////////////////////////////////////////////////

    // nothing leaves while held in reset
    a_idle_in_reset: assert property (@(posedge aclk) !arst_n |-> !m_tvalid)
    else begin
        fail_count++;
        $error("m_tvalid high during reset");
    end

    // stalled beat keeps its payload
    a_stable_payload: assert property (@(posedge aclk) disable iff (!arst_n)
        m_tvalid && !m_tready |=> $stable(m_tdata) && $stable(m_tlast))
    else begin
        fail_count++;
        $error("m_tdata or m_tlast changed while stalled");
    end

    // valid only drops after a handshake
    a_hold_valid: assert property (@(posedge aclk) disable iff (!arst_n)
        m_tvalid && !m_tready |=> m_tvalid)
    else begin
        fail_count++;
        $error("m_tvalid dropped before it was accepted");
    end

endmodule

bind axis_mul_shell axis_mul_assert u_assert (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tlast  (m_tlast)
);

/* test/tb_axis_mul.sv */
`timescale 1ns/1ps

module tb_axis_mul
    import mul_pkg::*, axis_pkg::*;
();

    localparam int DELAY    = 3;
    // beats per phase
    localparam int N_STREAM = 40;
    localparam int N_CORNER = 24;
    localparam int N_PKT    = 60;
    localparam int N_RAND   = 150;
    localparam int N_RST    = 30;
    // watchdog budget, eight cycles per beat plus slack
    localparam int MAX_CYCLES = (N_STREAM + N_CORNER + N_PKT + N_RAND + 2 * N_RST) * 8 + 200;

    logic          aclk;
    logic          arst_n;
    operand_pair_t s_tdata;
    logic          s_tvalid;
    logic          s_tready;
    logic          s_tlast;
    product_t      m_tdata;
    logic          m_tvalid;
    logic          m_tready;
    logic          m_tlast;

    // scoreboard, one entry per accepted input beat
    out_beat_t     exp_q [$];
    int            cyc_q [$];
    out_beat_t     exp_beat;
    int            in_cycle;

    string         test_name = "reset";
    logic [31:0]   src_state;
    logic [31:0]   sink_state;
    // percent of cycles with m_tready low
    int            bp_pct    = 0;
    logic          check_lat = 1'b0;
    int            cycle     = 0;
    int            err_data  = 0;
    int            err_last  = 0;
    int            err_lat   = 0;
    int            err_other = 0;

    axis_mul_shell #(
        .DELAY    (DELAY)
    ) u_dut (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    always @(posedge aclk) cycle <= cycle + 1;

    //////////////////////////////////////////////////
    // random source and reference
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(inout logic [31:0] state);
        logic [31:0] x;
        x = state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        state = x;
        return x;
    endfunction

    // true in about pct out of 100 calls
    function automatic logic hit_percent(inout logic [31:0] state, input int pct);
        return int'(xorshift(state) % 32'd100) < pct;
    endfunction

    // full width unsigned product
    function automatic product_t mul_ref(input operand_pair_t ops);
        return product_t'(ops.a) * product_t'(ops.b);
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_product(input product_t expected, input product_t actual);
        if (actual !== expected) begin
            err_data++;
            $display("** Error %s: product expected %h, actual %h",
                     test_name, expected, actual);
        end
    endtask

    task automatic check_last(input logic expected, input logic actual);
        if (actual !== expected) begin
            err_last++;
            $display("** Error %s: tlast expected %b, actual %b", test_name, expected, actual);
        end
    endtask

    task automatic check_latency(input int expected, input int actual);
        if (actual != expected) begin
            err_lat++;
            $display("** Error %s: latency expected %0d, actual %0d",
                     test_name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // scoreboard
    //////////////////////////////////////////////////

    // input side, every accepted beat queues its product
    always @(posedge aclk) begin
        if (arst_n && s_tvalid && s_tready) begin
            exp_q.push_back(out_beat_t'{last: s_tlast, data: mul_ref(s_tdata)});
            cyc_q.push_back(cycle);
        end
    end

    // output side, pop on every handshake
    always @(posedge aclk) begin
        if (arst_n && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                err_other++;
                $display("%s: an output beat arrived with nothing expected", test_name);
            end else begin
                exp_beat = exp_q.pop_front();
                in_cycle = cyc_q.pop_front();
                check_product(exp_beat.data, m_tdata);
                check_last(exp_beat.last, m_tlast);
                // guard, DELAY stages, skid register, then the output handshake
                if (check_lat) begin
                    check_latency(DELAY + 2, cycle - in_cycle);
                end
            end
        end
    end

    // sink, random back-pressure when bp_pct is set
    initial begin
        sink_state = ~32'd93;
        m_tready   = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            m_tready = (bp_pct == 0) || !hit_percent(sink_state, bp_pct);
        end
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge aclk);
        $display("timeout: outputs stopped, %0d beats never came out", exp_q.size());
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////

    // random idle cycles, then hold the beat until taken
    task automatic send_beat(input operand_pair_t ops, input logic last, input int gap_pct);
        while (hit_percent(src_state, gap_pct)) begin
            @(posedge aclk);
            #1;
        end
        s_tdata  = ops;
        s_tvalid = 1'b1;
        s_tlast  = last;
        @(posedge aclk);
        while (!s_tready) @(posedge aclk);
        #1;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // random operands, packets of 1 to 8 beats
    task automatic send_packets(input int n_beats, input int gap_pct);
        int left;
        left = 0;
        for (int i = 0; i < n_beats; i++) begin
            if (left == 0) begin
                left = 1 + int'(xorshift(src_state) % 32'd8);
            end
            send_beat(operand_pair_t'(xorshift(src_state)), left == 1 || i == n_beats - 1,
                      gap_pct);
            left--;
        end
    endtask

    task automatic send_corners();
        operand_t fixed_a [8];
        operand_t fixed_b [8];
        fixed_a = '{16'h0000, 16'h0000, 16'hffff, 16'hffff,
                    16'h0001, 16'hffff, 16'h8000, 16'h8000};
        fixed_b = '{16'h0000, 16'hffff, 16'h0000, 16'hffff,
                    16'hffff, 16'h0001, 16'h8000, 16'hffff};
        for (int i = 0; i < 8; i++) begin
            send_beat(operand_pair_t'({fixed_a[i], fixed_b[i]}), 1'b0, 0);
        end
        // single bits walking in opposite directions
        for (int i = 0; i < 16; i++) begin
            send_beat(operand_pair_t'({operand_t'(1) << i, operand_t'(1) << (15 - i)}),
                      i == 15, 0);
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge aclk);
        // extra cycles catch stray beats
        repeat (DELAY + 4) @(posedge aclk);
        #1;
    endtask

    // reset with beats still in flight
    task automatic mid_reset();
        arst_n   = 1'b0;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        exp_q.delete();
        cyc_q.delete();
        repeat (3) begin
            @(posedge aclk);
            if (m_tvalid !== 1'b0) begin
                err_other++;
                $display("%s: m_tvalid was not low during reset", test_name);
            end
            if (s_tready !== 1'b1) begin
                err_other++;
                $display("%s: s_tready was not high during reset", test_name);
            end
        end
        #1;
        arst_n = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        src_state = 32'd93;
        arst_n    = 1'b0;
        s_tdata   = '0;
        s_tvalid  = 1'b0;
        s_tlast   = 1'b0;
        repeat (3) @(posedge aclk);
        #1;
        arst_n = 1'b1;

        // back to back beats, fixed latency
        test_name = "streaming";
        check_lat = 1'b1;
        send_packets(N_STREAM, 0);
        drain();
        check_lat = 1'b0;

        test_name = "corner";
        send_corners();
        drain();

        test_name = "packets";
        send_packets(N_PKT, 30);
        drain();

        test_name = "backpressure";
        bp_pct    = 40;
        send_packets(N_RAND, 30);
        drain();

        test_name = "reset";
        send_packets(N_RST, 20);
        mid_reset();
        send_packets(N_RST, 20);
        drain();
        bp_pct = 0;

        err_other += u_dut.u_assert.fail_count;
        $display("errors: product %0d, last %0d, latency %0d, other %0d",
                 err_data, err_last, err_lat, err_other);
        if (err_data + err_last + err_lat + err_other == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
source/mul_pkg.sv
source/axis_pkg.sv
source/axis_if.sv
source/n_delay.sv
source/pipe_multiplier.sv
source/skid_buffer.sv
source/axis_mul_shell.sv
test/axis_mul_assert.sv
test/tb_axis_mul.sv

/* Makefile */
# simulator, options, top module and sources
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_axis_mul
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails unless the log has the pass line"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

# the log decides pass or fail, not the simulator exit code
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
